//--- Bender.yml
package:
  name: line_renderer

sources:
  - render_pkg.sv
  - cpu_regs.sv
  - line_counter.sv
  - fetch_fsm.sv
  - pixel_unpack.sv
  - line_buffer.sv
  - line_renderer.sv
  - target: test
    files:
      - tb_spi_model.sv
      - tb_line_renderer.sv

//--- cpu_regs.sv
// cpu register slave
// holds the 16-entry palette and the frame-buffer base, returns the scan
// position on any read, and serves palette lookups for the unpacker
module cpu_regs import render_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic [24:0] addr,
	input  word_t      din,
	input  logic       wen,
	input  logic       ren,
	input  vid_addr_t  curr_vid_addr,
	input  pix_idx_t   pal_index,
	output word_t      dout,
	output logic       ready,
	output mem_addr_t  fb_addr,
	output color_t     pal_color
);

	color_t palette [PALETTE_ENTRIES];
	logic done_q;
	logic access;
	logic reg_space;
	logic [17:0] word_index;

	// first cycle of a held strobe
	assign access = (wen || ren) && !done_q;

	// register space is the low 1M, addressed by word
	assign reg_space = (addr[23:20] == 4'd0);
	assign word_index = addr[19:2];

	// acknowledge one cycle after the strobe, for one cycle only
	assign ready = done_q && (wen || ren);

	// combinational lookup for the unpacker
	assign pal_color = palette[pal_index];

	always_ff @(posedge clk) begin
		if (reset) begin
			done_q <= 1'b0;
		end else begin
			// set on a fresh strobe, clear after the ready cycle
			done_q <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			palette <= DEFAULT_PALETTE;
			fb_addr <= FB_ADDR_RESET;
		end else if (access && wen && reg_space) begin
			if (word_index < 18'(PALETTE_ENTRIES)) begin
				palette[addr[5:2]] <= din[23:0];
			end else if (word_index == 18'(REG_FB_ADDR_INDEX)) begin
				fb_addr <= din[23:0];
			end
			// other indices are acknowledged and dropped
		end
	end

	// status word, valid in the ready cycle
	always_ff @(posedge clk) begin
		if (access && ren) begin
			dout <= {8'd0, curr_vid_addr, 4'd0};
		end
	end

	// a strobe still held after the acknowledge would start a second access
	assert property (@(posedge clk) disable iff (reset)
		ready |=> !(wen || ren));

endmodule

//--- fetch_fsm.sv
// fetch sequencer
// runs spi ram read bursts from fb_addr + pos/2, drops the read for refresh,
// at line end, on a full ring and at frame end
module fetch_fsm import render_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  vid_addr_t pos,
	input  logic      frame_done,
	input  logic      ring_free,
	input  logic      refresh_point,
	input  logic      next_field,
	input  logic      m_is_idle,
	input  mem_addr_t fb_addr,
	output logic      m_do_read,
	output mem_addr_t m_addr,
	output logic      run,
	output logic      restart
);

	fetch_state_t state_q;
	fetch_state_t state_d;
	logic start_ok;
	logic line_end;

	// last word of the visible line is being unpacked
	assign line_end = pos[8:0] > 9'(VISIBLE_PIXELS - PIXELS_PER_WORD);

	always_comb begin
		state_d = state_q;
		start_ok = 1'b0;
		unique case (state_q)
			IDLE_FRAME: begin
				if (next_field) begin
					state_d = WAIT_ROOM;
				end
			end
			WAIT_ROOM: begin
				if (frame_done) begin
					state_d = IDLE_FRAME;
				end else if (ring_free) begin
					state_d = START_READ;
				end
			end
			START_READ: begin
				if (frame_done) begin
					state_d = IDLE_FRAME;
				end else if (!ring_free) begin
					state_d = WAIT_ROOM;
				end else if (m_is_idle && pos[2:0] == 3'd0) begin
					// master stopped and no word in flight
					state_d = READING;
					start_ok = 1'b1;
				end
			end
			READING: begin
				if (!ring_free || line_end) begin
					state_d = WAIT_ROOM;
				end else if (refresh_point) begin
					state_d = REFRESH_DROP;
				end
			end
			REFRESH_DROP: begin
				// keep accepting words until the master has stopped
				if (!ring_free) begin
					state_d = WAIT_ROOM;
				end else if (m_is_idle) begin
					state_d = START_READ;
				end
			end
			default: begin
				state_d = WAIT_ROOM;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= WAIT_ROOM;
			m_do_read <= 1'b0;
		end else begin
			state_q <= state_d;
			m_do_read <= (state_d == READING);
		end
	end

	// burst start address, two pixels per byte
	always_ff @(posedge clk) begin
		if (start_ok) begin
			m_addr <= fb_addr + mem_addr_t'(pos >> 1);
		end
	end

	assign run = (state_q == READING) || (state_q == REFRESH_DROP);
	assign restart = (state_q == IDLE_FRAME);

	// no read burst runs into the end of the frame
	assert property (@(posedge clk) disable iff (reset)
		m_do_read |-> !frame_done);

endmodule

//--- line_buffer.sv
// line buffer
// four-line ring of colours, one write port and one registered read port
module line_buffer import render_pkg::*; (
	input  logic       clk,
	input  logic       wen,
	input  ring_addr_t waddr,
	input  color_t     wdata,
	input  ring_addr_t raddr,
	output color_t     rdata
);

	// 2048 entries, four strides of 512
	color_t mem [2 ** $bits(ring_addr_t)];

	always_ff @(posedge clk) begin
		if (wen) begin
			mem[waddr] <= wdata;
		end
	end

	// one cycle read latency
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

//--- line_counter.sv
// write position counter
// steps one per pixel, skips the invisible tail of each line, and decodes
// frame end, ring room and the spi ram refresh slot
module line_counter import render_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      pixel_step,
	input  logic      restart,
	input  logic      next_field,
	input  vid_addr_t curr_vid_addr,
	output vid_addr_t pos,
	output logic      frame_done,
	output logic      ring_free,
	output logic      refresh_point
);

	vid_addr_t pos_next;

	always_comb begin
		pos_next = pos;
		if (restart && next_field) begin
			// new field, back to line 0
			pos_next = '0;
		end else if (pixel_step) begin
			if (pos[8:0] == 9'(VISIBLE_PIXELS - 1)) begin
				// last visible pixel, jump to the next stride boundary
				pos_next = (pos & ~vid_addr_t'(LINE_STRIDE - 1)) + vid_addr_t'(LINE_STRIDE);
			end else begin
				pos_next = pos + 20'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pos <= POS_RESET;
			refresh_point <= 1'b0;
		end else begin
			pos <= pos_next;
			// one-cycle flag as the position arrives on the refresh slot
			refresh_point <= (pos_next != pos) && (pos_next[6:0] == REFRESH_POS);
		end
	end

	// all visible lines of the frame written
	assign frame_done = (pos[19:9] == 11'(FRAME_LINES));

	// room while the write line is not the scanned ring line
	assign ring_free = (pos[10:9] != curr_vid_addr[10:9]);

	// nothing is stepped once the last line of the frame is written
	assert property (@(posedge clk) disable iff (reset)
		frame_done |-> !pixel_step);

endmodule

//--- line_renderer.sv
// line renderer top
// cpu register slave, spi ram fetch and pixel unpack feeding the
// four-line ring that scan-out reads
module line_renderer import render_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	// cpu slave
	input  logic [24:0] addr,
	input  word_t       din,
	input  logic        wen,
	input  logic        ren,
	output word_t       dout,
	output logic        ready,
	// scan-out side
	input  vid_addr_t   curr_vid_addr,
	input  logic        next_field,
	input  ring_addr_t  scan_raddr,
	output color_t      scan_rdata,
	output logic        vid_wen,
	// spi ram master
	output logic        m_do_read,
	output mem_addr_t   m_addr,
	input  logic        m_next_byte,
	input  word_t       m_rdata,
	input  logic        m_is_idle
);

	mem_addr_t fb_addr;
	pix_idx_t pal_index;
	color_t pal_color;
	vid_addr_t pos;
	logic frame_done;
	logic ring_free;
	logic refresh_point;
	logic pixel_step;
	logic run;
	logic restart;
	ring_addr_t buf_waddr;
	color_t buf_wdata;

	cpu_regs i_cpu_regs (
		.clk           (clk),
		.reset         (reset),
		.addr          (addr),
		.din           (din),
		.wen           (wen),
		.ren           (ren),
		.curr_vid_addr (curr_vid_addr),
		.pal_index     (pal_index),
		.dout          (dout),
		.ready         (ready),
		.fb_addr       (fb_addr),
		.pal_color     (pal_color)
	);

	line_counter i_line_counter (
		.clk           (clk),
		.reset         (reset),
		.pixel_step    (pixel_step),
		.restart       (restart),
		.next_field    (next_field),
		.curr_vid_addr (curr_vid_addr),
		.pos           (pos),
		.frame_done    (frame_done),
		.ring_free     (ring_free),
		.refresh_point (refresh_point)
	);

	fetch_fsm i_fetch_fsm (
		.clk           (clk),
		.reset         (reset),
		.pos           (pos),
		.frame_done    (frame_done),
		.ring_free     (ring_free),
		.refresh_point (refresh_point),
		.next_field    (next_field),
		.m_is_idle     (m_is_idle),
		.fb_addr       (fb_addr),
		.m_do_read     (m_do_read),
		.m_addr        (m_addr),
		.run           (run),
		.restart       (restart)
	);

	// ring write strobe also goes out as vid_wen
	pixel_unpack i_pixel_unpack (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.pos         (pos),
		.m_next_byte (m_next_byte),
		.m_rdata     (m_rdata),
		.pal_color   (pal_color),
		.pal_index   (pal_index),
		.pixel_step  (pixel_step),
		.buf_wen     (vid_wen),
		.buf_waddr   (buf_waddr),
		.buf_wdata   (buf_wdata)
	);

	line_buffer i_line_buffer (
		.clk   (clk),
		.wen   (vid_wen),
		.waddr (buf_waddr),
		.wdata (buf_wdata),
		.raddr (scan_raddr),
		.rdata (scan_rdata)
	);

endmodule

//--- pixel_unpack.sv
// pixel unpacker
// captures a fetched word and writes its eight nibbles, mapped through the
// palette, into the line buffer on consecutive cycles
module pixel_unpack import render_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       run,
	input  vid_addr_t  pos,
	input  logic       m_next_byte,
	input  word_t      m_rdata,
	input  color_t     pal_color,
	output pix_idx_t   pal_index,
	output logic       pixel_step,
	output logic       buf_wen,
	output ring_addr_t buf_waddr,
	output color_t     buf_wdata
);

	word_t word_q;
	word_t word_cur;
	logic active_q;
	logic take;

	// a word is only taken while the sequencer is reading
	assign take = m_next_byte && run;

	// first pixel comes straight from the bus
	assign word_cur = take ? m_rdata : word_q;

	// nibble by position, low nibble first
	assign pal_index = word_cur[4 * pos[2:0] +: 4];

	// step on the strobe and on each following nibble of the word
	assign pixel_step = take || active_q;

	always_ff @(posedge clk) begin
		if (take) begin
			word_q <= m_rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			active_q <= 1'b0;
			buf_wen <= 1'b0;
		end else begin
			// stop after the eighth nibble
			active_q <= pixel_step && (pos[2:0] != 3'(PIXELS_PER_WORD - 1));
			buf_wen <= pixel_step;
		end
	end

	// write address is the position before the step
	always_ff @(posedge clk) begin
		if (pixel_step) begin
			buf_waddr <= pos[10:0];
			buf_wdata <= pal_color;
		end
	end

endmodule

//--- render_pkg.sv
// render package
// shared widths, frame geometry, register map and reset values of the line renderer
package render_pkg;

	// 24-bit rgb colour
	typedef logic [23:0] color_t;
	// 4-bit palette index, one packed pixel
	typedef logic [3:0] pix_idx_t;
	// write/scan position: [19:9] line, [10:9] ring line, [8:0] pixel
	typedef logic [19:0] vid_addr_t;
	// physical ring address, low bits of a position
	typedef logic [10:0] ring_addr_t;
	// spi ram byte address
	typedef logic [23:0] mem_addr_t;
	// cpu and spi data word
	typedef logic [31:0] word_t;

	// fetch sequencer states
	typedef enum logic [2:0] {
		IDLE_FRAME,
		WAIT_ROOM,
		START_READ,
		READING,
		REFRESH_DROP
	} fetch_state_t;

	// frame geometry, in pixels and lines
	localparam int unsigned LINE_STRIDE = 512;
	localparam int unsigned VISIBLE_PIXELS = 480;
	localparam int unsigned FRAME_LINES = 320;
	localparam int unsigned PIXELS_PER_WORD = 8;
	// spi ram refresh slot, low 7 position bits
	localparam logic [6:0] REFRESH_POS = 7'h70;
	// write position after reset, two lines ahead of scan-out
	localparam vid_addr_t POS_RESET = 20'h400;

	// register map
	localparam int unsigned PALETTE_ENTRIES = 16;
	localparam int unsigned REG_FB_ADDR_INDEX = 16;
	// top 128K of the spi ram
	localparam mem_addr_t FB_ADDR_RESET = 24'h7E0000;

	// standard 16-colour set
	localparam color_t DEFAULT_PALETTE [PALETTE_ENTRIES] = '{
		24'h000000, 24'h000080, 24'h008000, 24'h008080,
		24'h800000, 24'h800080, 24'h808000, 24'h808080,
		24'h404040, 24'h0000ff, 24'h00ff00, 24'h00ffff,
		24'hff0000, 24'hff00ff, 24'hffff00, 24'hffffff
	};

endpackage

//--- tb_line_renderer.sv
// line renderer testbench
// applies a table of cpu accesses and render checks, steps the scan line to
// keep the ring moving, and models the write position and burst addresses
module tb_line_renderer import render_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_TESTS = 16;
	// worst case cycles to render one line
	localparam int LINE_CYCLES = 1000;
	localparam int STALL_LIMIT = 4000;
	localparam logic [2:0] OP_WRITE = 3'd0;
	localparam logic [2:0] OP_READ = 3'd1;
	localparam logic [2:0] OP_RENDER = 3'd2;
	localparam logic [2:0] OP_FRAME_END = 3'd3;
	localparam logic [2:0] OP_FIELD = 3'd4;

	typedef struct packed {
		logic [2:0]  op;
		logic [24:0] addr;
		word_t       data;
		word_t       exp;
		logic [10:0] line;
	} stim_t;

	logic clk;
	logic reset;
	logic [24:0] addr;
	word_t din;
	logic wen;
	logic ren;
	word_t dout;
	logic ready;
	vid_addr_t curr_vid_addr;
	logic next_field;
	ring_addr_t scan_raddr;
	color_t scan_rdata;
	logic vid_wen;
	logic m_do_read;
	mem_addr_t m_addr;
	logic m_next_byte;
	word_t m_rdata;
	logic m_is_idle;

	stim_t stim [NUM_TESTS];
	color_t exp_pal [PALETTE_ENTRIES];
	mem_addr_t exp_fb;
	// expected write position, stepped on every ring write
	vid_addr_t tb_pos;
	logic prev_read;
	int scan_line;
	int errors;
	int checks;
	int err_before;
	word_t rd;
	color_t tail_ref [4][32];
	logic tail_seen [4];

	line_renderer i_dut (
		.clk           (clk),
		.reset         (reset),
		.addr          (addr),
		.din           (din),
		.wen           (wen),
		.ren           (ren),
		.dout          (dout),
		.ready         (ready),
		.curr_vid_addr (curr_vid_addr),
		.next_field    (next_field),
		.scan_raddr    (scan_raddr),
		.scan_rdata    (scan_rdata),
		.vid_wen       (vid_wen),
		.m_do_read     (m_do_read),
		.m_addr        (m_addr),
		.m_next_byte   (m_next_byte),
		.m_rdata       (m_rdata),
		.m_is_idle     (m_is_idle)
	);

	tb_spi_model i_spi (
		.clk         (clk),
		.reset       (reset),
		.m_do_read   (m_do_read),
		.m_addr      (m_addr),
		.m_next_byte (m_next_byte),
		.m_rdata     (m_rdata),
		.m_is_idle   (m_is_idle)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// whole run bound, every test may take up to a full frame
	initial begin
		#(longint'(NUM_TESTS) * FRAME_LINES * LINE_CYCLES * CLK_PERIOD);
		$display("watchdog timeout, fetch state %s", i_dut.i_fetch_fsm.state_q.name());
		$display("** FAIL **");
		$finish;
	end

	task automatic check_word(input word_t got, input word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_color(input color_t got, input color_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic fail_note(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	function automatic stim_t entry(input logic [2:0] op, input logic [24:0] a,
			input word_t d, input word_t e, input int line);
		stim_t s;
		s.op = op;
		s.addr = a;
		s.data = d;
		s.exp = e;
		s.line = 11'(line);
		return s;
	endfunction

	// 480 visible pixels, then on to the next 512 boundary
	function automatic vid_addr_t step_pos(input vid_addr_t p);
		if (p[8:0] == 9'(VISIBLE_PIXELS - 1)) begin
			return {p[19:9] + 11'd1, 9'd0};
		end
		return p + 20'd1;
	endfunction

	// two pixels per byte, low nibble first
	function automatic color_t expect_pixel(input int line, input int px);
		mem_addr_t a;
		logic [7:0] b;
		a = exp_fb + mem_addr_t'((line * LINE_STRIDE + px) / 2);
		b = i_spi.mem[a[17:0]];
		return exp_pal[px[0] ? b[7:4] : b[3:0]];
	endfunction

	// position and burst monitor
	always @(posedge clk) begin
		if (reset) begin
			tb_pos = POS_RESET;
			prev_read = 1'b0;
		end else begin
			if (vid_wen) begin
				if (tb_pos[19:9] >= 11'(FRAME_LINES)) begin
					fail_note("ring write after the last line of the frame");
				end
				if (tb_pos[10:9] == curr_vid_addr[10:9]) begin
					fail_note("ring write into the line being scanned");
				end
				tb_pos = step_pos(tb_pos);
			end
			if (m_do_read && !prev_read) begin
				check_addr(m_addr, exp_fb + mem_addr_t'(tb_pos >> 1), "burst start address");
			end
			prev_read = m_do_read;
			if (next_field && tb_pos[19:9] == 11'(FRAME_LINES)) begin
				tb_pos = '0;
			end
		end
	end

	task automatic cpu_access(input logic write, input logic [24:0] a, input word_t d,
			output word_t rdata);
		int n;
		@(posedge clk);
		#2;
		addr = a;
		din = d;
		wen = write;
		ren = !write;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
		end while (!ready && n < 8);
		rdata = dout;
		if (n != 1 || !ready) begin
			fail_note($sformatf("cpu access to %h not acknowledged after one cycle", a));
		end
		#1;
		wen = 1'b0;
		ren = 1'b0;
		@(posedge clk);
		#1;
		if (ready) begin
			fail_note("ready held for more than one cycle");
		end
	endtask

	task automatic set_scan(input int line);
		scan_line = line;
		curr_vid_addr = vid_addr_t'(line) << 9;
	endtask

	// step the scan line whenever the writer stalls, until the line is done
	task automatic render_to(input int line);
		int idle;
		vid_addr_t last;
		idle = 0;
		last = tb_pos;
		while (int'(tb_pos[19:9]) <= line && idle < STALL_LIMIT) begin
			@(posedge clk);
			#2;
			if (tb_pos == (vid_addr_t'(scan_line + 4) << 9) && scan_line < line - 1) begin
				set_scan(scan_line + 1);
			end
			if (tb_pos != last) begin
				last = tb_pos;
				idle = 0;
			end else begin
				idle++;
			end
		end
		if (idle >= STALL_LIMIT) begin
			fail_note($sformatf("rendering stopped at position %h", tb_pos));
		end
	endtask

	// wait until the ring is full or the frame is over, then hold there
	task automatic wait_stall();
		int n;
		n = 0;
		while (tb_pos != (vid_addr_t'(scan_line + 4) << 9) &&
				tb_pos[19:9] != 11'(FRAME_LINES) && n < STALL_LIMIT) begin
			@(posedge clk);
			#1;
			n++;
		end
		repeat (16) begin
			@(posedge clk);
			#1;
			if (vid_wen) begin
				fail_note("ring written while the writer should be stalled");
			end
		end
		if (m_do_read) begin
			fail_note("spi read still active while stalled");
		end
	endtask

	task automatic check_line(input int line);
		int ring;
		ring = line & 3;
		for (int px = 0; px < LINE_STRIDE; px++) begin
			@(posedge clk);
			#2;
			scan_raddr = {2'(ring), 9'(px)};
			@(posedge clk);
			#1;
			if (px < VISIBLE_PIXELS) begin
				check_color(scan_rdata, expect_pixel(line, px),
					$sformatf("line %0d pixel %0d", line, px));
			end else if (!tail_seen[ring]) begin
				tail_ref[ring][px - VISIBLE_PIXELS] = scan_rdata;
			end else begin
				// tail entries are never written, they read the same every time
				check_color(scan_rdata, tail_ref[ring][px - VISIBLE_PIXELS],
					$sformatf("line %0d tail pixel %0d", line, px));
			end
		end
		tail_seen[ring] = 1'b1;
	endtask

	initial begin
		reset = 1'b1;
		addr = '0;
		din = '0;
		wen = 1'b0;
		ren = 1'b0;
		curr_vid_addr = '0;
		next_field = 1'b0;
		scan_raddr = '0;
		exp_pal = DEFAULT_PALETTE;
		exp_fb = FB_ADDR_RESET;
		scan_line = 0;
		errors = 0;
		checks = 0;
		for (int i = 0; i < 4; i++) begin
			tail_seen[i] = 1'b0;
		end

		// reset state, default palette from line 2 onward
		stim[0] = entry(OP_RENDER, 25'h0, 32'h0, 32'h0, 2);
		stim[1] = entry(OP_RENDER, 25'h0, 32'h0, 32'h0, 7);
		// palette entries 0, 5 and 15
		stim[2] = entry(OP_WRITE, 25'h00, 32'h00123456, 32'h0, 0);
		stim[3] = entry(OP_WRITE, 25'h14, 32'h00a5c3e1, 32'h0, 0);
		stim[4] = entry(OP_WRITE, 25'h3c, 32'h000f1e2d, 32'h0, 0);
		// unmapped, outside register space and past fb_addr
		stim[5] = entry(OP_WRITE, 25'h100000, 32'hdeadbeef, 32'h0, 0);
		stim[6] = entry(OP_WRITE, 25'h44, 32'h00001111, 32'h0, 0);
		stim[7] = entry(OP_RENDER, 25'h0, 32'h0, 32'h0, 12);
		stim[8] = entry(OP_RENDER, 25'h0, 32'h0, 32'h0, 200);
		stim[9] = entry(OP_FRAME_END, 25'h0, 32'h0, 32'h0, 319);
		// status reads, scan position shifted by 4
		stim[10] = entry(OP_READ, 25'h80, 32'h0002a5f3, 32'h002a5f30, 0);
		stim[11] = entry(OP_READ, 25'h0, 32'h000fffff, 32'h00fffff0, 0);
		// new frame-buffer base, used from the next field
		stim[12] = entry(OP_WRITE, 25'h40, 32'h007e2000, 32'h0, 0);
		stim[13] = entry(OP_FIELD, 25'h0, 32'h0, 32'h0, 0);
		stim[14] = entry(OP_RENDER, 25'h0, 32'h0, 32'h0, 0);
		stim[15] = entry(OP_RENDER, 25'h0, 32'h0, 32'h0, 5);

		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;
		#1;
		if (ready !== 1'b0 || m_do_read !== 1'b0) begin
			fail_note("ready or m_do_read not low after reset");
		end

		for (int t = 0; t < NUM_TESTS; t++) begin
			err_before = errors;
			case (stim[t].op)
				OP_WRITE: begin
					cpu_access(1'b1, stim[t].addr, stim[t].data, rd);
					if (stim[t].addr[23:20] == 4'd0 &&
							stim[t].addr[19:2] < 18'(PALETTE_ENTRIES)) begin
						exp_pal[stim[t].addr[5:2]] = stim[t].data[23:0];
					end else if (stim[t].addr[23:20] == 4'd0 &&
							stim[t].addr[19:2] == 18'(REG_FB_ADDR_INDEX)) begin
						exp_fb = stim[t].data[23:0];
					end
				end
				OP_READ: begin
					@(posedge clk);
					#2;
					curr_vid_addr = stim[t].data[19:0];
					cpu_access(1'b0, stim[t].addr, 32'h0, rd);
					check_word(rd, stim[t].exp, "status read");
				end
				OP_RENDER: begin
					render_to(int'(stim[t].line));
					check_line(int'(stim[t].line));
					wait_stall();
				end
				OP_FRAME_END: begin
					render_to(FRAME_LINES - 1);
					check_line(FRAME_LINES - 1);
					wait_stall();
					if (i_dut.i_fetch_fsm.state_q != IDLE_FRAME) begin
						fail_note($sformatf("fetch sequencer in %s at frame end",
							i_dut.i_fetch_fsm.state_q.name()));
					end
				end
				default: begin
					// next field, scan sits on ring line 1 while line 0 is written
					@(posedge clk);
					#2;
					set_scan(-3);
					next_field = 1'b1;
					@(posedge clk);
					#2;
					next_field = 1'b0;
				end
			endcase
			$display("test %0d op %0d line %0d: %s", t, stim[t].op, stim[t].line,
				(errors == err_before) ? "ok" : "failed");
		end

		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- tb_spi_model.sv
// spi ram model
// byte array filled from a seeded random stream, returns consecutive words of
// a read burst with one strobe per word and reports idle once stopped
module tb_spi_model import render_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      m_do_read,
	input  mem_addr_t m_addr,
	output logic      m_next_byte,
	output word_t     m_rdata,
	output logic      m_is_idle
);
	timeunit 1ns;
	timeprecision 1ps;

	// 256K bytes, addresses wrap on the low 18 bits
	localparam int MEM_BYTES = 2 ** 18;
	// cycles between word strobes
	localparam int WORD_GAP = 8;
	// outputs change this long after the rising edge
	localparam int DRIVE_DELAY = 2;

	logic [7:0] mem [MEM_BYTES];
	integer seed;
	logic busy;
	logic do_read_s;
	logic reset_s;
	mem_addr_t addr_s;
	mem_addr_t rd_addr;
	int gap;

	initial begin
		seed = 32'h3d50;
		for (int i = 0; i < MEM_BYTES; i++) begin
			mem[i] = 8'($random(seed));
		end
		busy = 1'b0;
		gap = 0;
		rd_addr = '0;
		m_next_byte = 1'b0;
		m_rdata = '0;
		m_is_idle = 1'b1;
	end

	always @(posedge clk) begin
		// sample at the edge, drive a little later
		do_read_s = m_do_read;
		addr_s = m_addr;
		reset_s = reset;
		#DRIVE_DELAY;
		m_next_byte = 1'b0;
		if (reset_s) begin
			busy = 1'b0;
			m_is_idle = 1'b1;
		end else if (!busy) begin
			if (do_read_s) begin
				// burst start, address taken once
				busy = 1'b1;
				m_is_idle = 1'b0;
				rd_addr = addr_s;
				gap = WORD_GAP - 1;
			end else begin
				m_is_idle = 1'b1;
			end
		end else if (!do_read_s) begin
			// read dropped, stop without another word
			busy = 1'b0;
			m_is_idle = 1'b1;
		end else if (gap == 0) begin
			// little endian, byte at the lowest address in bits 7:0
			m_rdata = {mem[18'(rd_addr + 3)], mem[18'(rd_addr + 2)],
				mem[18'(rd_addr + 1)], mem[18'(rd_addr)]};
			m_next_byte = 1'b1;
			rd_addr = rd_addr + 24'd4;
			gap = WORD_GAP - 1;
		end else begin
			gap = gap - 1;
		end
	end

endmodule

//--- verilog.f
render_pkg.sv
cpu_regs.sv
line_counter.sv
fetch_fsm.sv
pixel_unpack.sv
line_buffer.sv
line_renderer.sv
tb_spi_model.sv
tb_line_renderer.sv
